/* src/vector_config.svh */
`ifndef VECTOR_CONFIG_SVH
`define VECTOR_CONFIG_SVH

// Operands reduced per request, must be a power of two
`define LANES 8

// Entries in the destination vector
`define NUM_ELEMENTS 8

// Half precision field widths
`define FP_EXP_W 5
`define FP_FRAC_W 10

// log2 of LANES, one level of ALUs per step
`define TREE_LEVELS 3

`endif

/* src/vector_pkg.sv */
`include "vector_config.svh"

package vector_pkg;

    // Half precision value, sign in the top bit
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fp16_t;

    typedef enum logic [1:0] {
        RED_SUM = 2'd0,
        RED_MAX = 2'd1,
        RED_MIN = 2'd2
    } red_op_e;

    typedef fp16_t [`LANES-1:0]        lane_vec_t;
    typedef fp16_t [`NUM_ELEMENTS-1:0] elem_vec_t;

    // Fields that only steer the output stage
    typedef struct packed {
        logic [$clog2(`NUM_ELEMENTS)-1:0] imm;
        logic                             broadcast;
        logic                             clear;
    } red_ctrl_t;

    typedef struct packed {
        red_op_e   op;
        red_ctrl_t ctrl;
        lane_vec_t lanes;
        elem_vec_t vector;
    } red_req_t;

endpackage

/* src/param_sr.sv */
`timescale 1ns/100ps

module param_sr #(
    parameter int WIDTH  = 8,
    parameter int STAGES = 2
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out
);
    logic [WIDTH-1:0] sr [0:STAGES-1];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < STAGES; s++) begin
                sr[s] <= '0;
            end
        end else begin
            sr[0] <= data_in;
            for (int s = 1; s < STAGES; s++) begin
                sr[s] <= sr[s-1];
            end
        end
    end

    assign data_out = sr[STAGES-1];

endmodule

/* src/reduction_alu.sv */
`timescale 1ns/100ps
`include "vector_config.svh"

module reduction_alu import vector_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    input  fp16_t   a,
    input  fp16_t   b,
    input  red_op_e op,
    output fp16_t   y
);
    localparam int EW = `FP_EXP_W;
    localparam int FW = `FP_FRAC_W;
    // Significand with the hidden bit
    localparam int SW = FW + 1;
    localparam int LZW = $clog2(SW);
    localparam logic [EW+1:0] EXP_MAX = {2'b00, {EW{1'b1}}};

    fp16_t         a_f;
    fp16_t         b_f;
    fp16_t         big;
    fp16_t         small_f;
    logic          a_mag_gt;
    logic          a_mag_lt;
    logic          b_gt_a;
    logic          b_lt_a;
    logic [EW-1:0] exp_diff;
    logic [SW-1:0] big_sig;
    logic [SW-1:0] small_sig;

    red_op_e       s1_op;
    fp16_t         s1_sel;
    logic          s1_sign;
    logic          s1_sub;
    logic [EW-1:0] s1_exp;
    logic [SW-1:0] s1_big_sig;
    logic [SW-1:0] s1_small_sig;

    logic [SW:0]    sum;
    logic [SW:0]    norm;
    logic [LZW-1:0] lz;
    logic [EW+1:0]  exp_wide;
    fp16_t          sum_res;

    // Denormals flush to +0
    assign a_f = (a.exp == '0) ? '0 : a;
    assign b_f = (b.exp == '0) ? '0 : b;

    assign a_mag_gt = {a_f.exp, a_f.frac} > {b_f.exp, b_f.frac};
    assign a_mag_lt = {a_f.exp, a_f.frac} < {b_f.exp, b_f.frac};

    // Equal values leave both flags low so a wins
    assign b_gt_a = (a_f.sign & ~b_f.sign) | (~a_f.sign & ~b_f.sign & a_mag_lt)
                  | (a_f.sign & b_f.sign & a_mag_gt);
    assign b_lt_a = (~a_f.sign & b_f.sign) | (~a_f.sign & ~b_f.sign & a_mag_gt)
                  | (a_f.sign & b_f.sign & a_mag_lt);

    assign big     = a_mag_lt ? b_f : a_f;
    assign small_f = a_mag_lt ? a_f : b_f;

    assign exp_diff  = big.exp - small_f.exp;
    assign big_sig   = (big.exp == '0) ? '0 : {1'b1, big.frac};
    // Bits shifted out are dropped so the sum truncates
    assign small_sig = (small_f.exp == '0) ? '0 : ({1'b1, small_f.frac} >> exp_diff);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            s1_op        <= RED_SUM;
            s1_sel       <= '0;
            s1_sign      <= 1'b0;
            s1_sub       <= 1'b0;
            s1_exp       <= '0;
            s1_big_sig   <= '0;
            s1_small_sig <= '0;
        end else begin
            s1_op        <= op;
            s1_sel       <= (op == RED_MAX) ? (b_gt_a ? b_f : a_f) : (b_lt_a ? b_f : a_f);
            s1_sign      <= big.sign;
            s1_sub       <= a_f.sign ^ b_f.sign;
            s1_exp       <= big.exp;
            s1_big_sig   <= big_sig;
            s1_small_sig <= small_sig;
        end
    end

    // Big magnitude first so a subtraction never goes negative
    assign sum = s1_sub ? ({1'b0, s1_big_sig} - {1'b0, s1_small_sig})
                        : ({1'b0, s1_big_sig} + {1'b0, s1_small_sig});

    // Leading zeros below the carry bit
    always_comb begin
        lz = '0;
        for (int i = 0; i < SW; i++) begin
            if (sum[i]) begin
                lz = LZW'(SW - 1 - i);
            end
        end
    end

    always_comb begin
        if (sum[SW]) begin
            exp_wide = {2'b00, s1_exp} + 1'b1;
            norm     = sum >> 1;
        end else begin
            exp_wide = {2'b00, s1_exp} - lz;
            norm     = sum << lz;
        end

        if (sum == '0 || (!sum[SW] && lz >= s1_exp)) begin
            // Exact cancellation or a result below the normal range
            sum_res = '0;
        end else if (exp_wide >= EXP_MAX) begin
            sum_res = '{sign: s1_sign, exp: '1, frac: '0};
        end else begin
            sum_res = '{sign: s1_sign, exp: exp_wide[EW-1:0], frac: norm[FW-1:0]};
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            y <= '0;
        end else begin
            y <= (s1_op == RED_SUM) ? sum_res : s1_sel;
        end
    end

endmodule

/* src/reduction_tree.sv */
`timescale 1ns/100ps
`include "vector_config.svh"

module reduction_tree import vector_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  lane_vec_t data_in,
    input  red_op_e   op,
    input  logic      valid_in,
    output fp16_t     data_out,
    output logic      valid_out
);
    localparam int N = `LANES;
    // Lane inputs followed by every ALU output, level by level
    localparam int NODES = 2 * N - 1;

    fp16_t   node      [0:NODES-1];
    red_op_e op_lvl    [0:`TREE_LEVELS];
    logic    valid_lvl [0:`TREE_LEVELS];

    assign op_lvl[0]    = op;
    assign valid_lvl[0] = valid_in;

    for (genvar i = 0; i < N; i++) begin : g_lane
        assign node[i] = data_in[i];
    end

    for (genvar k = 0; k < `TREE_LEVELS; k++) begin : g_level
        localparam int IN_BASE  = 2 * N - ((2 * N) >> k);
        localparam int OUT_BASE = 2 * N - (N >> k);

        red_op_e op_mid;
        red_op_e op_q;
        logic    valid_mid;
        logic    valid_q;

        // Two registers to match the ALU latency
        always_ff @(posedge CLK or negedge nRST) begin
            if (!nRST) begin
                op_mid    <= RED_SUM;
                op_q      <= RED_SUM;
                valid_mid <= 1'b0;
                valid_q   <= 1'b0;
            end else begin
                op_mid    <= op_lvl[k];
                op_q      <= op_mid;
                valid_mid <= valid_lvl[k];
                valid_q   <= valid_mid;
            end
        end

        assign op_lvl[k+1]    = op_q;
        assign valid_lvl[k+1] = valid_q;

        for (genvar j = 0; j < (N >> (k + 1)); j++) begin : g_alu
            reduction_alu u_alu (
                .CLK (CLK),
                .nRST(nRST),
                .a   (node[IN_BASE + 2 * j]),
                .b   (node[IN_BASE + 2 * j + 1]),
                .op  (op_lvl[k]),
                .y   (node[OUT_BASE + j])
            );
        end
    end

    assign data_out  = node[NODES-1];
    assign valid_out = valid_lvl[`TREE_LEVELS];

endmodule

/* src/vreduction.sv */
`timescale 1ns/100ps
`include "vector_config.svh"

module vreduction import vector_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  red_req_t  req,
    input  logic      input_valid,
    output elem_vec_t vector_output,
    output logic      output_valid
);
    // Two ALU stages per tree level
    localparam int TREE_STAGES = 2 * `TREE_LEVELS;

    fp16_t     tree_result;
    logic      tree_valid;
    elem_vec_t vec_in;
    elem_vec_t vec_d;
    red_ctrl_t ctrl_d;
    elem_vec_t next_vector;

    reduction_tree u_tree (
        .CLK      (CLK),
        .nRST     (nRST),
        .data_in  (req.lanes),
        .op       (req.op),
        .valid_in (input_valid),
        .data_out (tree_result),
        .valid_out(tree_valid)
    );

    // Side-band fields travel beside the tree
    param_sr #(
        .WIDTH ($bits(red_ctrl_t)),
        .STAGES(TREE_STAGES)
    ) ctrl_pipe (
        .CLK     (CLK),
        .nRST    (nRST),
        .data_in (req.ctrl),
        .data_out(ctrl_d)
    );

    // Idle slots carry zeros
    assign vec_in = input_valid ? req.vector : '0;

    param_sr #(
        .WIDTH ($bits(elem_vec_t)),
        .STAGES(TREE_STAGES)
    ) vec_pipe (
        .CLK     (CLK),
        .nRST    (nRST),
        .data_in (vec_in),
        .data_out(vec_d)
    );

    always_comb begin
        for (int i = 0; i < `NUM_ELEMENTS; i++) begin
            if (ctrl_d.broadcast) begin
                next_vector[i] = tree_result;
            end else if (int'(ctrl_d.imm) == i) begin
                next_vector[i] = tree_result;
            end else if (ctrl_d.clear) begin
                next_vector[i] = '0;
            end else begin
                // Keep the destination element
                next_vector[i] = vec_d[i];
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            vector_output <= '0;
            output_valid  <= 1'b0;
        end else begin
            vector_output <= next_vector;
            output_valid  <= tree_valid;
        end
    end

endmodule

/* testbench/vreduction_tb.sv */
`timescale 1ns/100ps
`include "vector_config.svh"

module vreduction_tb import vector_pkg::*; ();
    // Falling edges from the issuing edge to the visible result
    localparam int LATENCY = 7;
    localparam int BIAS = 15;

    logic      CLK = 1'b0;
    logic      nRST;
    red_req_t  req;
    logic      input_valid;
    elem_vec_t vector_output;
    logic      output_valid;

    int        cyc = 0;
    int        due_q[$];
    elem_vec_t exp_q[$];
    int        checks = 0;
    int        errors = 0;
    int        errors_before = 0;
    int        tests_run = 0;
    bit        timed_out = 1'b0;

    vreduction vreduction_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .req          (req),
        .input_valid  (input_valid),
        .vector_output(vector_output),
        .output_valid (output_valid)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cyc <= cyc + 1;
    end

    function automatic real fp16_value(input fp16_t f);
        real v;
        int  e;
        if (f.exp == '0) begin
            return 0.0;
        end
        v = 1.0 + real'(f.frac) / 1024.0;
        for (e = int'(f.exp); e > BIAS; e--) begin
            v = v * 2.0;
        end
        for (e = int'(f.exp); e < BIAS; e++) begin
            v = v / 2.0;
        end
        return f.sign ? -v : v;
    endfunction

    // Exact encoding for magnitudes below 2048
    function automatic fp16_t int_to_fp16(input int v);
        fp16_t f;
        int    mag;
        int    p;
        int    field;
        f = '0;
        if (v == 0) begin
            return f;
        end
        f.sign = (v < 0);
        mag = (v < 0) ? -v : v;
        p = 0;
        while ((mag >> (p + 1)) != 0) begin
            p++;
        end
        field = p + BIAS;
        f.exp = field[4:0];
        field = mag << (10 - p);
        f.frac = field[9:0];
        return f;
    endfunction

    function automatic fp16_t small_int_value();
        int v;
        v = int'($urandom_range(40)) - 20;
        return int_to_fp16(v);
    endfunction

    // Any normal value of either sign
    function automatic fp16_t random_normal();
        fp16_t       f;
        logic [31:0] bits;
        int          e;
        bits = $urandom;
        e = 1 + int'($urandom_range(29));
        f.sign = bits[15];
        f.exp = e[4:0];
        f.frac = bits[9:0];
        return f;
    endfunction

    function automatic fp16_t reference_result(input red_op_e op, input lane_vec_t lanes);
        fp16_t best;
        real   total;
        best = lanes[0];
        total = 0.0;
        for (int i = 0; i < `LANES; i++) begin
            total = total + fp16_value(lanes[i]);
            if (op == RED_MAX && fp16_value(lanes[i]) > fp16_value(best)) begin
                best = lanes[i];
            end
            if (op == RED_MIN && fp16_value(lanes[i]) < fp16_value(best)) begin
                best = lanes[i];
            end
        end
        // Integer lanes keep every partial sum exact
        return (op == RED_SUM) ? int_to_fp16(int'(total)) : best;
    endfunction

    function automatic elem_vec_t expected_vector(input red_req_t r);
        elem_vec_t v;
        fp16_t     res;
        res = reference_result(r.op, r.lanes);
        for (int i = 0; i < `NUM_ELEMENTS; i++) begin
            if (r.ctrl.broadcast || int'(r.ctrl.imm) == i) begin
                v[i] = res;
            end else if (r.ctrl.clear) begin
                v[i] = '0;
            end else begin
                v[i] = r.vector[i];
            end
        end
        return v;
    endfunction

    function automatic red_req_t make_request(input red_op_e op, input bit bcast, input bit clr);
        red_req_t    r;
        logic [31:0] bits;
        bits = $urandom;
        r.op = op;
        r.ctrl.imm = bits[$bits(r.ctrl.imm)-1:0];
        r.ctrl.broadcast = bcast;
        r.ctrl.clear = clr;
        for (int i = 0; i < `LANES; i++) begin
            r.lanes[i] = (op == RED_SUM) ? small_int_value() : random_normal();
        end
        for (int i = 0; i < `NUM_ELEMENTS; i++) begin
            bits = $urandom;
            r.vector[i] = bits[15:0];
        end
        return r;
    endfunction

    task automatic send(input red_req_t r);
        req = r;
        input_valid = 1'b1;
        due_q.push_back(cyc + LATENCY);
        exp_q.push_back(expected_vector(r));
        @(negedge CLK);
    endtask

    task automatic idle(input int n);
        input_valid = 1'b0;
        req = '0;
        repeat (n) @(negedge CLK);
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        idle(0);
        while (due_q.size() != 0 && n < 4 * LATENCY) begin
            @(negedge CLK);
            n++;
        end
        if (due_q.size() != 0) begin
            $display("timeout: %s results never arrived", what);
            timed_out = 1'b1;
        end
        idle(2);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %s done, %0d errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    task automatic check_zero_output();
        checks++;
        assert (vector_output == '0) else begin
            errors++;
            $display("error at %0t: vector_output %h is not zero", $time, vector_output);
        end
    endtask

    // Valid follows the issue schedule and data follows the queue head
    always @(negedge CLK) begin : output_check
        logic due_now;
        due_now = (due_q.size() > 0) && (due_q[0] == cyc);
        checks++;
        assert (output_valid == due_now) else begin
            errors++;
            $display("error at %0t: output_valid %0b, expected %0b", $time, output_valid, due_now);
        end
        if (due_now) begin
            checks++;
            assert (vector_output == exp_q[0]) else begin
                errors++;
                $display("error at %0t: vector_output %h, expected %h",
                         $time, vector_output, exp_q[0]);
            end
            void'(due_q.pop_front());
            void'(exp_q.pop_front());
        end
    end

    task automatic reset_test();
        repeat (2) begin
            @(negedge CLK);
            check_zero_output();
        end
        nRST = 1'b1;
        repeat (8) begin
            @(negedge CLK);
            check_zero_output();
        end
        end_test("reset");
    endtask

    task automatic broadcast_sum_test();
        int n;
        send(make_request(RED_SUM, 1'b1, 1'b0));
        idle(0);
        n = 1;
        while (!output_valid && n < 3 * LATENCY) begin
            @(negedge CLK);
            n++;
        end
        if (!output_valid) begin
            $display("timeout: broadcast sum result never arrived");
            timed_out = 1'b1;
        end else begin
            checks++;
            assert (n == LATENCY) else begin
                errors++;
                $display("error at %0t: result after %0d cycles, expected %0d", $time, n, LATENCY);
            end
        end
        wait_drain("broadcast sum");
        end_test("broadcast_sum");
    endtask

    task automatic max_min_insert_test();
        for (int i = 0; i < 4; i++) begin
            send(make_request(RED_MAX, 1'b0, 1'b0));
            send(make_request(RED_MIN, 1'b0, 1'b0));
            idle(2);
        end
        wait_drain("max and min");
        end_test("max_min_insert");
    endtask

    task automatic clear_test();
        send(make_request(RED_SUM, 1'b0, 1'b1));
        idle(1);
        send(make_request(RED_MAX, 1'b0, 1'b1));
        send(make_request(RED_MIN, 1'b0, 1'b1));
        wait_drain("clear");
        end_test("clear");
    endtask

    task automatic stream_test();
        logic [31:0] bits;
        for (int i = 0; i < 20; i++) begin
            bits = $urandom;
            send(make_request(red_op_e'($urandom_range(2)), bits[0], bits[1]));
        end
        wait_drain("stream");
        end_test("back_to_back");
    endtask

    task automatic gap_test();
        logic [31:0] bits;
        for (int i = 0; i < 12; i++) begin
            bits = $urandom;
            send(make_request(red_op_e'($urandom_range(2)), bits[0], bits[1]));
            idle(int'($urandom_range(5, 1)));
        end
        wait_drain("gaps");
        end_test("gaps");
    endtask

    initial begin
        void'($urandom(32'h701f));
        nRST = 1'b0;
        input_valid = 1'b0;
        req = '0;
        reset_test();
        if (!timed_out) broadcast_sum_test();
        if (!timed_out) max_min_insert_test();
        if (!timed_out) clear_test();
        if (!timed_out) stream_test();
        if (!timed_out) gap_test();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+src
src/vector_pkg.sv
src/param_sr.sv
src/reduction_alu.sv
src/reduction_tree.sv
src/vreduction.sv
testbench/vreduction_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the RTL and testbench with Verilator, then run the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module vreduction_tb -f files.f \
    -o vreduction_sim || { echo "build failed"; exit 1; }

# Output is kept in memory so it can be shown and searched
sim_out=$(./obj_dir/vreduction_sim)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "TESTBENCH PASSED" && echo "simulation ok" || {
    echo "simulation reported failure"
    exit 1
}
